// File: verilog/led_cal_pkg.sv
package led_cal_pkg;

    // raster geometry, kept tiny so the id memory stays small
    localparam int H_ACTIVE = 16;
    localparam int V_ACTIVE = 8;
    localparam int H_TOTAL = 20;
    localparam int V_TOTAL = 10;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    // led strip
    localparam int NUM_LEDS = 30;
    localparam int ID_WIDTH = $clog2(NUM_LEDS);

    // lane 0 tests cr and writes a 0 bit, lane 1 tests cb and writes a 1 bit
    localparam int NUM_LANES = 2;

    // coordinate on the outputs to its id readback
    localparam int PIPE_DELAY = 3;

    // raster coordinates
    typedef logic [4:0] hcount_t;
    typedef logic [3:0] vcount_t;

    // one chroma sample or threshold
    typedef logic [7:0] chroma_t;

    // led id and the index of the address bit one step writes
    typedef logic [ID_WIDTH-1:0] led_id_t;
    typedef logic [2:0] bit_sel_t;

    // per-frame hit tally, 128 active pixels at most
    typedef logic [7:0] hit_count_t;

    // id memory address, line * H_ACTIVE + column
    typedef logic [6:0] pix_addr_t;

    // calibration step states
    typedef enum logic [1:0] {
        STEP_IDLE,
        STEP_ARMED,
        STEP_CAPTURE
    } step_state_t;

endpackage

// File: verilog/video_timing.sv
module video_timing
    import led_cal_pkg::*;
(
    input  logic    clk_pixel,
    input  logic    sys_rst_pixel,
    output hcount_t hcount,
    output vcount_t vcount,
    output logic    active_draw,
    output logic    new_frame
);

    logic h_wrap;
    logic v_wrap;

    // end of line and end of frame
    assign h_wrap = (hcount == hcount_t'(H_TOTAL - 1));
    assign v_wrap = (vcount == vcount_t'(V_TOTAL - 1));

    // horizontal counter wraps at H_TOTAL
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            hcount <= '0;
        end else if (h_wrap) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + hcount_t'(1);
        end
    end

    // line counter steps once per line wrap
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            vcount <= '0;
        end else if (h_wrap) begin
            if (v_wrap) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + vcount_t'(1);
            end
        end
    end

    // decoded straight from the counters, same cycle as the coordinate
    always_comb begin
        active_draw = (hcount < hcount_t'(H_ACTIVE)) && (vcount < vcount_t'(V_ACTIVE));
        // single cycle at the top left corner
        new_frame = (hcount == '0) && (vcount == '0);
    end

    // counters must stay inside the raster
    a_raster_bounds : assert property (
        @(posedge clk_pixel) disable iff (sys_rst_pixel)
        (hcount < hcount_t'(H_TOTAL)) && (vcount < vcount_t'(V_TOTAL))
    );

endmodule

// File: verilog/chroma_threshold.sv
module chroma_threshold
    import led_cal_pkg::*;
(
    input  logic       clk_pixel,
    input  logic       sys_rst_pixel,
    input  chroma_t    sample,
    input  chroma_t    lower_bound,
    input  chroma_t    upper_bound,
    input  logic       active,
    input  logic       frame_start,
    output logic       mask,
    output hit_count_t hit_count,
    output logic       hit_valid
);

    logic       in_window;
    hit_count_t tally;

    // inclusive window on both ends
    assign in_window = (sample >= lower_bound) && (sample <= upper_bound);

    // one register stage, blanking never marks
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            mask <= 1'b0;
        end else begin
            mask <= active && in_window;
        end
    end

    // running tally of marked pixels in the current frame
    // the mask at frame_start belongs to the last blanking pixel
    // so the tally already holds the whole frame
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            tally <= '0;
        end else if (frame_start) begin
            tally <= '0;
        end else if (mask) begin
            tally <= tally + hit_count_t'(1);
        end
    end

    // finished frame's count, with a one cycle strobe
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            hit_count <= '0;
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= frame_start;
            if (frame_start) begin
                hit_count <= tally;
            end
        end
    end

    // the frame closes in blanking, no mark may be pending then
    a_no_mark_at_frame_start : assert property (
        @(posedge clk_pixel) disable iff (sys_rst_pixel)
        frame_start |-> !mask
    );

endmodule

// File: verilog/led_id_map.sv
module led_id_map
    import led_cal_pkg::*;
(
    input  logic     clk_pixel,
    input  logic     sys_rst_pixel,
    input  hcount_t  hcount,
    input  vcount_t  vcount,
    input  logic     active,
    input  logic     frame_start,
    input  logic     mask_zero,
    input  logic     mask_one,
    input  logic     start_step,
    input  logic     first_step,
    input  bit_sel_t bit_sel,
    input  led_id_t  sel_led,
    output logic     step_busy,
    output led_id_t  led_id,
    output logic     id_valid,
    output logic     mark_pixel
);

    localparam int MEM_WORDS = H_ACTIVE * V_ACTIVE;
    localparam int CNT_WIDTH = $clog2(FRAME_CYCLES);

    step_state_t          state;
    bit_sel_t             bit_sel_q;
    logic                 first_q;
    logic [CNT_WIDTH-1:0] capture_cnt;

    // coordinate delayed to line up with the lane masks
    hcount_t   hcount_d;
    vcount_t   vcount_d;
    logic      active_d;
    pix_addr_t addr;

    led_id_t   mem [MEM_WORDS];
    led_id_t   rd_word;
    led_id_t   wr_word;
    logic      mem_we;
    logic      capturing;

    // step sequencing
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            state       <= STEP_IDLE;
            bit_sel_q   <= '0;
            first_q     <= 1'b0;
            capture_cnt <= '0;
        end else begin
            case (state)
                STEP_IDLE: begin
                    // requests while busy are simply dropped
                    if (start_step) begin
                        state     <= STEP_ARMED;
                        bit_sel_q <= bit_sel;
                        first_q   <= first_step;
                    end
                end
                STEP_ARMED: begin
                    // capture starts as pixel (0,0) reaches the write stage
                    if (frame_start) begin
                        state       <= STEP_CAPTURE;
                        capture_cnt <= '0;
                    end
                end
                STEP_CAPTURE: begin
                    // exactly one frame of cycles
                    if (capture_cnt == CNT_WIDTH'(FRAME_CYCLES - 1)) begin
                        state <= STEP_IDLE;
                    end else begin
                        capture_cnt <= capture_cnt + CNT_WIDTH'(1);
                    end
                end
                default: begin
                    state <= STEP_IDLE;
                end
            endcase
        end
    end

    assign step_busy = (state != STEP_IDLE);
    assign capturing = (state == STEP_CAPTURE);

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            hcount_d <= '0;
            vcount_d <= '0;
            active_d <= 1'b0;
        end else begin
            hcount_d <= hcount;
            vcount_d <= vcount;
            active_d <= active;
        end
    end

    // row major, blanking addresses wrap but are never written
    assign addr = pix_addr_t'(vcount_d) * pix_addr_t'(H_ACTIVE) + pix_addr_t'(hcount_d);
    assign rd_word = mem[addr];

    // read-modify-write of the selected bit
    always_comb begin
        wr_word = first_q ? '0 : rd_word;
        // lane 1 wins over lane 0
        if (mask_one) begin
            wr_word[bit_sel_q] = 1'b1;
        end else if (mask_zero) begin
            wr_word[bit_sel_q] = 1'b0;
        end
        // first step rewrites every active pixel to clear stale ids
        mem_we = capturing && active_d && (first_q || mask_one || mask_zero);
    end

    // small register file, cleared on reset
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mem_we) begin
            mem[addr] <= wr_word;
        end
    end

    // readback, PIPE_DELAY after the coordinate left the timing generator
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            id_valid   <= 1'b0;
            mark_pixel <= 1'b0;
        end else begin
            id_valid   <= active_d && !capturing;
            mark_pixel <= active_d && !capturing && (rd_word == sel_led);
        end
    end

    // id of the pixel being read back
    always_ff @(posedge clk_pixel) begin
        led_id <= rd_word;
    end

    // an accepted step must select a real address bit
    a_bit_sel_range : assert property (
        @(posedge clk_pixel) disable iff (sys_rst_pixel)
        (state == STEP_IDLE && start_step) |=> (bit_sel_q < bit_sel_t'(ID_WIDTH))
    );

    // the capture frame closes in blanking
    // so every write is followed by another capture cycle
    a_write_in_capture : assert property (
        @(posedge clk_pixel) disable iff (sys_rst_pixel)
        mem_we |=> capturing
    );

endmodule

// File: verilog/led_locator_top.sv
module led_locator_top
    import led_cal_pkg::*;
(
    input  logic       clk_pixel,
    input  logic       sys_rst_pixel,
    input  chroma_t    pixel_cr,
    input  chroma_t    pixel_cb,
    input  chroma_t    lower_threshold,
    input  chroma_t    upper_threshold,
    input  logic       start_step,
    input  logic       first_step,
    input  bit_sel_t   bit_sel,
    input  led_id_t    sel_led,
    output hcount_t    hcount,
    output vcount_t    vcount,
    output logic       active_draw,
    output logic       new_frame,
    output hit_count_t hit_count_cr,
    output hit_count_t hit_count_cb,
    output logic       hit_valid,
    output logic       step_busy,
    output led_id_t    led_id,
    output logic       id_valid,
    output logic       mark_pixel
);

    // raster copies aligned with the incoming pixel samples
    hcount_t hcount_q;
    vcount_t vcount_q;
    logic    active_q;
    logic    frame_start_q;

    // per-lane signals, index 0 is cr, index 1 is cb
    chroma_t    lane_sample [NUM_LANES];
    logic       lane_mask   [NUM_LANES];
    hit_count_t lane_count  [NUM_LANES];
    logic       lane_valid  [NUM_LANES];

    video_timing u_timing (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .hcount       (hcount),
        .vcount       (vcount),
        .active_draw  (active_draw),
        .new_frame    (new_frame)
    );

    // samples arrive one cycle after their coordinate
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            hcount_q      <= '0;
            vcount_q      <= '0;
            active_q      <= 1'b0;
            frame_start_q <= 1'b0;
        end else begin
            hcount_q      <= hcount;
            vcount_q      <= vcount;
            active_q      <= active_draw;
            frame_start_q <= new_frame;
        end
    end

    assign lane_sample[0] = pixel_cr;
    assign lane_sample[1] = pixel_cb;

    // same window on both lanes
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        chroma_threshold u_lane (
            .clk_pixel    (clk_pixel),
            .sys_rst_pixel(sys_rst_pixel),
            .sample       (lane_sample[i]),
            .lower_bound  (lower_threshold),
            .upper_bound  (upper_threshold),
            .active       (active_q),
            .frame_start  (frame_start_q),
            .mask         (lane_mask[i]),
            .hit_count    (lane_count[i]),
            .hit_valid    (lane_valid[i])
        );

        // no lane can count more than the active pixels of one frame
        a_tally_bound : assert property (
            @(posedge clk_pixel) disable iff (sys_rst_pixel)
            lane_valid[i] |-> (lane_count[i] <= hit_count_t'(H_ACTIVE * V_ACTIVE))
        );
    end

    assign hit_count_cr = lane_count[0];
    assign hit_count_cb = lane_count[1];
    assign hit_valid    = lane_valid[0];

    led_id_map u_id_map (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .hcount       (hcount_q),
        .vcount       (vcount_q),
        .active       (active_q),
        .frame_start  (frame_start_q),
        .mask_zero    (lane_mask[0]),
        .mask_one     (lane_mask[1]),
        .start_step   (start_step),
        .first_step   (first_step),
        .bit_sel      (bit_sel),
        .sel_led      (sel_led),
        .step_busy    (step_busy),
        .led_id       (led_id),
        .id_valid     (id_valid),
        .mark_pixel   (mark_pixel)
    );

endmodule

// File: verification/tb_checker.sv
module tb_checker
    import led_cal_pkg::*;
(
    input  logic       clk_pixel,
    input  logic       sys_rst_pixel,
    input  chroma_t    pixel_cr,
    input  chroma_t    pixel_cb,
    input  chroma_t    lower_threshold,
    input  chroma_t    upper_threshold,
    input  logic       start_step,
    input  logic       first_step,
    input  bit_sel_t   bit_sel,
    input  led_id_t    sel_led,
    input  hcount_t    hcount,
    input  vcount_t    vcount,
    input  logic       active_draw,
    input  logic       new_frame,
    input  hit_count_t hit_count_cr,
    input  hit_count_t hit_count_cb,
    input  logic       hit_valid,
    input  logic       step_busy,
    input  led_id_t    led_id,
    input  logic       id_valid,
    input  logic       mark_pixel,
    output logic       timed_out
);

    timeunit 1ns;
    timeprecision 1ps;

    // five steps of up to two frames plus an idle frame each, and some slack
    localparam int TIMEOUT_CYCLES = 15 * FRAME_CYCLES + 1000;

    int unsigned cycle_cnt = 0;
    int test_checks = 0;
    int test_errors = 0;
    int total_checks = 0;
    int total_errors = 0;
    int tests_done = 0;

    // expected raster position
    int exp_h;
    int exp_v;

    // coordinate seen in the cycle before
    hcount_t prev_h;
    vcount_t prev_v;
    logic    prev_act;
    logic    prev_ok;

    // pixel pair of this cycle and of the one before (write stage)
    logic      pair_act;
    logic      pair_m0;
    logic      pair_m1;
    logic      pair_first;
    logic      last_ok;
    logic      last_act;
    logic      last_m0;
    logic      last_m1;
    pix_addr_t last_addr;

    // tallies
    int   cur_cr;
    int   cur_cb;
    int   done_cr;
    int   done_cb;
    logic exp_hv;

    // id memory model and step FSM
    led_id_t     mem_m [H_ACTIVE * V_ACTIVE];
    led_id_t     wr;
    step_state_t m_state;
    int          cap_cnt;
    bit_sel_t    m_bit;
    logic        m_first;

    // readback expected in the next cycle
    logic    exp_idv;
    logic    exp_mark;
    led_id_t exp_id;

    function automatic logic in_window(chroma_t s, chroma_t lo, chroma_t hi);
        return (s >= lo) && (s <= hi);
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        test_checks++;
        if (expected != actual) begin
            test_errors++;
            $display("** Error at %0d ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_done++;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic final_counts(output int errors);
        $display("tests %0d, checks %0d, errors %0d", tests_done, total_checks, total_errors);
        errors = total_errors;
    endtask

    always @(posedge clk_pixel) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES && timed_out !== 1'b1) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            timed_out <= 1'b1;
        end
        if (sys_rst_pixel) begin
            timed_out <= 1'b0;
            exp_h     = 0;
            exp_v     = 0;
            prev_ok   = 1'b0;
            last_ok   = 1'b0;
            last_act  = 1'b0;
            exp_hv    = 1'b0;
            exp_idv   = 1'b0;
            exp_mark  = 1'b0;
            cur_cr    = 0;
            cur_cb    = 0;
            done_cr   = 0;
            done_cb   = 0;
            m_state   = STEP_IDLE;
            cap_cnt   = 0;
            m_first   = 1'b0;
            m_bit     = '0;
            for (int i = 0; i < H_ACTIVE * V_ACTIVE; i++) begin
                mem_m[i] = '0;
            end
        end else begin
            // raster
            check_value("hcount", exp_h, int'(hcount));
            check_value("vcount", exp_v, int'(vcount));
            check_value("active_draw", int'(exp_h < H_ACTIVE && exp_v < V_ACTIVE),
                        int'(active_draw));
            check_value("new_frame", int'(exp_h == 0 && exp_v == 0), int'(new_frame));
            if (exp_h == H_TOTAL - 1) begin
                exp_h = 0;
                exp_v = (exp_v == V_TOTAL - 1) ? 0 : exp_v + 1;
            end else begin
                exp_h++;
            end

            // outputs predicted one cycle ago
            check_value("step_busy", int'(m_state != STEP_IDLE), int'(step_busy));
            check_value("hit_valid", int'(exp_hv), int'(hit_valid));
            if (exp_hv) begin
                check_value("hit_count_cr", done_cr, int'(hit_count_cr));
                check_value("hit_count_cb", done_cb, int'(hit_count_cb));
            end
            check_value("id_valid", int'(exp_idv), int'(id_valid));
            check_value("mark_pixel", int'(exp_mark), int'(mark_pixel));
            if (exp_idv) begin
                check_value("led_id", int'(exp_id), int'(led_id));
            end

            // samples of this cycle go with the previous coordinate
            pair_act   = prev_ok && prev_act;
            pair_m0    = pair_act && in_window(pixel_cr, lower_threshold, upper_threshold);
            pair_m1    = pair_act && in_window(pixel_cb, lower_threshold, upper_threshold);
            pair_first = prev_ok && prev_h == 0 && prev_v == 0;

            // a frame's tally closes when its first pixel pair comes in
            exp_hv = pair_first;
            if (pair_first) begin
                done_cr = cur_cr;
                done_cb = cur_cb;
                cur_cr  = 0;
                cur_cb  = 0;
            end
            cur_cr += int'(pair_m0);
            cur_cb += int'(pair_m1);

            // readback sees the memory before this cycle's write
            exp_idv  = last_ok && last_act && (m_state != STEP_CAPTURE);
            exp_id   = mem_m[last_addr];
            exp_mark = exp_idv && (exp_id == sel_led);

            // write stage works on the previous pair
            if (m_state == STEP_CAPTURE && last_ok && last_act) begin
                wr = m_first ? '0 : mem_m[last_addr];
                if (last_m1) begin
                    wr[m_bit] = 1'b1;
                end else if (last_m0) begin
                    wr[m_bit] = 1'b0;
                end
                if (m_first || last_m0 || last_m1) begin
                    mem_m[last_addr] = wr;
                end
            end

            // step FSM, requests outside idle fall away
            case (m_state)
                STEP_IDLE: begin
                    if (start_step) begin
                        m_state = STEP_ARMED;
                        m_bit   = bit_sel;
                        m_first = first_step;
                    end
                end
                STEP_ARMED: begin
                    if (pair_first) begin
                        m_state = STEP_CAPTURE;
                        cap_cnt = 0;
                    end
                end
                default: begin
                    if (cap_cnt == FRAME_CYCLES - 1) begin
                        m_state = STEP_IDLE;
                    end else begin
                        cap_cnt++;
                    end
                end
            endcase

            last_ok   = prev_ok;
            last_act  = pair_act;
            last_m0   = pair_m0;
            last_m1   = pair_m1;
            last_addr = pix_addr_t'(prev_v) * pix_addr_t'(H_ACTIVE) + pix_addr_t'(prev_h);
            prev_h    = hcount;
            prev_v    = vcount;
            prev_act  = active_draw;
            prev_ok   = 1'b1;
        end
    end

endmodule

// File: verification/tb_top.sv
module tb_top
    import led_cal_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic       clk_pixel;
    logic       sys_rst_pixel;
    chroma_t    pixel_cr;
    chroma_t    pixel_cb;
    chroma_t    lower_threshold;
    chroma_t    upper_threshold;
    logic       start_step;
    logic       first_step;
    bit_sel_t   bit_sel;
    led_id_t    sel_led;
    hcount_t    hcount;
    vcount_t    vcount;
    logic       active_draw;
    logic       new_frame;
    hit_count_t hit_count_cr;
    hit_count_t hit_count_cb;
    logic       hit_valid;
    logic       step_busy;
    led_id_t    led_id;
    logic       id_valid;
    logic       mark_pixel;
    logic       timed_out;
    int         error_total;

    led_locator_top DUT (
        .clk_pixel      (clk_pixel),
        .sys_rst_pixel  (sys_rst_pixel),
        .pixel_cr       (pixel_cr),
        .pixel_cb       (pixel_cb),
        .lower_threshold(lower_threshold),
        .upper_threshold(upper_threshold),
        .start_step     (start_step),
        .first_step     (first_step),
        .bit_sel        (bit_sel),
        .sel_led        (sel_led),
        .hcount         (hcount),
        .vcount         (vcount),
        .active_draw    (active_draw),
        .new_frame      (new_frame),
        .hit_count_cr   (hit_count_cr),
        .hit_count_cb   (hit_count_cb),
        .hit_valid      (hit_valid),
        .step_busy      (step_busy),
        .led_id         (led_id),
        .id_valid       (id_valid),
        .mark_pixel     (mark_pixel)
    );

    tb_checker u_checker (
        .clk_pixel      (clk_pixel),
        .sys_rst_pixel  (sys_rst_pixel),
        .pixel_cr       (pixel_cr),
        .pixel_cb       (pixel_cb),
        .lower_threshold(lower_threshold),
        .upper_threshold(upper_threshold),
        .start_step     (start_step),
        .first_step     (first_step),
        .bit_sel        (bit_sel),
        .sel_led        (sel_led),
        .hcount         (hcount),
        .vcount         (vcount),
        .active_draw    (active_draw),
        .new_frame      (new_frame),
        .hit_count_cr   (hit_count_cr),
        .hit_count_cb   (hit_count_cb),
        .hit_valid      (hit_valid),
        .step_busy      (step_busy),
        .led_id         (led_id),
        .id_valid       (id_valid),
        .mark_pixel     (mark_pixel),
        .timed_out      (timed_out)
    );

    // 10 ns pixel clock
    initial begin
        clk_pixel = 1'b0;
        forever #5 clk_pixel = ~clk_pixel;
    end

    // fresh random chroma on every edge, belongs to the coordinate of the cycle before
    always @(posedge clk_pixel) begin
        pixel_cr <= chroma_t'($urandom);
        pixel_cb <= chroma_t'($urandom);
    end

    // the checker raises this when the cycle budget runs out
    always @(posedge clk_pixel) begin
        if (timed_out === 1'b1) begin
            $display("Simulation failed");
            $finish;
        end
    end

    // one calibration step on one address bit, with a dropped request while busy
    task automatic run_step(input int bit_index, input logic first);
        chroma_t low;
        chroma_t span;
        low  = chroma_t'($urandom_range(0, 127));
        span = chroma_t'($urandom_range(0, 127));
        @(posedge clk_pixel);
        lower_threshold <= low;
        upper_threshold <= low + span;
        sel_led         <= led_id_t'($urandom_range(0, NUM_LEDS - 1));
        bit_sel         <= bit_sel_t'(bit_index);
        first_step      <= first;
        start_step      <= 1'b1;
        @(posedge clk_pixel);
        start_step <= 1'b0;
        first_step <= 1'b0;
        // busy shows up one cycle after the request is taken
        do begin
            @(posedge clk_pixel);
        end while (!step_busy);
        repeat (50) @(posedge clk_pixel);
        // this one must be ignored, the map is busy
        start_step <= 1'b1;
        first_step <= 1'b1;
        bit_sel    <= bit_sel_t'((bit_index + 1) % ID_WIDTH);
        @(posedge clk_pixel);
        start_step <= 1'b0;
        first_step <= 1'b0;
        do begin
            @(posedge clk_pixel);
        end while (step_busy);
        // one quiet frame so every pixel is read back
        sel_led <= led_id_t'($urandom_range(0, NUM_LEDS - 1));
        repeat (FRAME_CYCLES) @(posedge clk_pixel);
    endtask

    initial begin
        sys_rst_pixel   = 1'b1;
        pixel_cr        = '0;
        pixel_cb        = '0;
        lower_threshold = '0;
        upper_threshold = '0;
        start_step      = 1'b0;
        first_step      = 1'b0;
        bit_sel         = '0;
        sel_led         = '0;
        error_total     = 0;
        void'($urandom(21861));
        repeat (2) @(posedge clk_pixel);
        sys_rst_pixel <= 1'b0;
        repeat (4) @(posedge clk_pixel);
        // test boundaries fall between edges, away from the checker
        @(negedge clk_pixel);
        u_checker.finish_test("reset");
        for (int b = 0; b < ID_WIDTH; b++) begin
            run_step(b, b == 0);
            @(negedge clk_pixel);
            u_checker.finish_test($sformatf("step on bit %0d", b));
        end
        u_checker.final_counts(error_total);
        if (error_total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/led_cal_pkg.sv
verilog/video_timing.sv
verilog/chroma_threshold.sv
verilog/led_id_map.sv
verilog/led_locator_top.sv
verification/tb_checker.sv
verification/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict from the printed output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f verilog.f \
    || { echo "build error"; exit 1; }

out=$(./obj_dir/Vtb_top)
echo "$out"

echo "$out" | grep -q "Simulation passed" && exit 0 || exit 1
